/* hdl/dma_pkg.sv */
// Shared widths and bus types of the DMA transport layer
// Requests never span a word boundary: offset + num_bytes stays within StrbWidth
`default_nettype none

package dma_pkg;

    localparam int unsigned DataWidth   = 32;
    localparam int unsigned StrbWidth   = DataWidth / 8;
    localparam int unsigned AddrWidth   = 8;
    localparam int unsigned OffsetWidth = 2;
    localparam int unsigned BufferDepth = 3;

    typedef logic [7:0]           byte_t;
    typedef logic [StrbWidth-1:0] strb_t;

    typedef enum logic {
        PROTO_MEM  = 1'b0,
        PROTO_INIT = 1'b1
    } protocol_e;

    // ------------------------------------------------------------
    // Datapath requests and responses
    // ------------------------------------------------------------
    typedef struct packed {
        protocol_e              src_protocol;
        logic [AddrWidth-1:0]   addr;
        logic [OffsetWidth-1:0] offset;
        logic [OffsetWidth:0]   num_bytes;
        logic [OffsetWidth-1:0] shift;
        byte_t                  fill_byte;
    } r_dp_req_t;

    typedef struct packed {
        logic [AddrWidth-1:0]   addr;
        logic [OffsetWidth-1:0] offset;
        logic [OffsetWidth:0]   num_bytes;
    } w_dp_req_t;

    typedef struct packed {
        logic error;
    } w_dp_rsp_t;

    // ------------------------------------------------------------
    // Memory ports
    // ------------------------------------------------------------
    typedef struct packed {
        logic                 req;
        logic [AddrWidth-1:0] addr;
    } mem_rd_req_t;

    typedef struct packed {
        logic                 rvalid;
        logic [DataWidth-1:0] rdata;
    } mem_rd_rsp_t;

    typedef struct packed {
        logic                 req;
        logic [AddrWidth-1:0] addr;
        logic [DataWidth-1:0] wdata;
        strb_t                be;
    } mem_wr_req_t;

    typedef struct packed {
        logic gnt;
    } mem_wr_rsp_t;

    // Lanes offset .. offset+num_bytes-1 of one word
    function automatic strb_t lane_mask(input logic [OffsetWidth-1:0] offset,
                                        input logic [OffsetWidth:0]   num_bytes);
        strb_t mask;
        for (int unsigned i = 0; i < StrbWidth; i++) begin
            mask[i] = (i >= offset) && (i < offset + num_bytes);
        end
        return mask;
    endfunction

endpackage

`default_nettype wire

/* hdl/dma_mem_read.sv */
// Reads one word per request and hands the masked bytes to the buffer
// The request must stay on req_i until done is accepted
`timescale 1ns/1ps
`default_nettype none

module dma_mem_read (
    input  logic                                       clk_i,
    input  logic                                       reset_i,
    input  dma_pkg::r_dp_req_t                         req_i,
    input  logic                                       valid_i,
    output logic                                       done_o,
    input  logic                                       done_ready_i,
    output dma_pkg::mem_rd_req_t                       mem_req_o,
    input  dma_pkg::mem_rd_rsp_t                       mem_rsp_i,
    output dma_pkg::byte_t [dma_pkg::StrbWidth-1:0]    lane_data_o,
    output dma_pkg::strb_t                             lane_valid_o,
    input  dma_pkg::strb_t                             lane_ready_i
);

    typedef enum logic [2:0] {
        RD_IDLE,
        RD_REQUEST,
        RD_WAIT,
        RD_PUSH,
        RD_DONE
    } rd_state_e;

    rd_state_e                      state_q, state_d;
    dma_pkg::strb_t                 pending_q, pending_d;
    logic [dma_pkg::DataWidth-1:0]  word_q;
    logic                           capture;

    always_comb begin
        state_d        = state_q;
        pending_d      = pending_q;
        capture        = 1'b0;
        mem_req_o      = '0;
        mem_req_o.addr = req_i.addr;
        lane_valid_o   = '0;
        done_o         = 1'b0;
        case (state_q)
            RD_IDLE: begin
                if (valid_i) begin
                    state_d = RD_REQUEST;
                end
            end
            RD_REQUEST, RD_WAIT: begin
                // Single cycle request, the answer may come in the same cycle
                mem_req_o.req = (state_q == RD_REQUEST);
                state_d       = RD_WAIT;
                if (mem_rsp_i.rvalid) begin
                    capture   = 1'b1;
                    pending_d = dma_pkg::lane_mask(req_i.offset, req_i.num_bytes);
                    state_d   = RD_PUSH;
                end
            end
            RD_PUSH: begin
                lane_valid_o = pending_q;
                pending_d    = pending_q & ~lane_ready_i;
                if (pending_d == '0) begin
                    state_d = RD_DONE;
                end
            end
            RD_DONE: begin
                done_o = 1'b1;
                if (done_ready_i) begin
                    state_d = RD_IDLE;
                end
            end
            default: state_d = RD_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q   <= RD_IDLE;
            pending_q <= '0;
        end else begin
            state_q   <= state_d;
            pending_q <= pending_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            word_q <= mem_rsp_i.rdata;
        end
    end

    assign lane_data_o = word_q;

    // Memory must only answer an issued request
    a_no_rvalid_in_idle: assert property (@(posedge clk_i) disable iff (reset_i)
        (state_q == RD_IDLE) |-> !mem_rsp_i.rvalid);

endmodule

`default_nettype wire

/* hdl/dma_init_read.sv */
// Fill-pattern source, offers fill_byte on every requested lane
`timescale 1ns/1ps
`default_nettype none

module dma_init_read (
    input  logic                                       clk_i,
    input  logic                                       reset_i,
    input  dma_pkg::r_dp_req_t                         req_i,
    input  logic                                       valid_i,
    output logic                                       done_o,
    input  logic                                       done_ready_i,
    output dma_pkg::byte_t [dma_pkg::StrbWidth-1:0]    lane_data_o,
    output dma_pkg::strb_t                             lane_valid_o,
    input  dma_pkg::strb_t                             lane_ready_i
);

    // Lanes already taken by the buffer for the current request
    dma_pkg::strb_t accepted_q;
    dma_pkg::strb_t pending;

    assign pending      = dma_pkg::lane_mask(req_i.offset, req_i.num_bytes) & ~accepted_q;
    assign lane_valid_o = valid_i ? pending : '0;
    assign lane_data_o  = {dma_pkg::StrbWidth{req_i.fill_byte}};

    // Done as soon as the last lanes are being accepted
    assign done_o = valid_i && ((pending & ~lane_ready_i) == '0);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            accepted_q <= '0;
        end else if (done_o && done_ready_i) begin
            accepted_q <= '0;
        end else begin
            accepted_q <= accepted_q | (lane_valid_o & lane_ready_i);
        end
    end

endmodule

`default_nettype wire

/* hdl/dma_byte_buffer.sv */
// Reorder buffer with one independent FIFO per byte lane
// Depth must be 2 or more
`timescale 1ns/1ps
`default_nettype none

module dma_byte_buffer #(
    parameter int unsigned Depth = dma_pkg::BufferDepth
) (
    input  logic                                       clk_i,
    input  logic                                       reset_i,
    input  dma_pkg::byte_t [dma_pkg::StrbWidth-1:0]    data_i,
    input  dma_pkg::strb_t                             valid_i,
    output dma_pkg::strb_t                             ready_o,
    output dma_pkg::byte_t [dma_pkg::StrbWidth-1:0]    data_o,
    output dma_pkg::strb_t                             valid_o,
    input  dma_pkg::strb_t                             ready_i
);

    localparam int unsigned PtrWidth = $clog2(Depth);
    localparam int unsigned CntWidth = $clog2(Depth + 1);

    for (genvar l = 0; l < dma_pkg::StrbWidth; l++) begin : gen_lane
        dma_pkg::byte_t        mem_q [Depth];
        logic [PtrWidth-1:0]   wr_ptr_q;
        logic [PtrWidth-1:0]   rd_ptr_q;
        logic [CntWidth-1:0]   cnt_q;
        logic                  push;
        logic                  pop;

        assign ready_o[l] = (cnt_q < CntWidth'(Depth));
        assign valid_o[l] = (cnt_q != '0);
        assign data_o[l]  = mem_q[rd_ptr_q];

        assign push = valid_i[l] && ready_o[l];
        assign pop  = valid_o[l] && ready_i[l];

        always_ff @(posedge clk_i) begin
            if (reset_i) begin
                wr_ptr_q <= '0;
                rd_ptr_q <= '0;
                cnt_q    <= '0;
            end else begin
                if (push) begin
                    wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
                end
                if (pop) begin
                    rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
                end
                if (push && !pop) begin
                    cnt_q <= cnt_q + 1'b1;
                end else if (pop && !push) begin
                    cnt_q <= cnt_q - 1'b1;
                end
            end
        end

        always_ff @(posedge clk_i) begin
            if (push) begin
                mem_q[wr_ptr_q] <= data_i[l];
            end
        end

        a_cnt_in_range: assert property (@(posedge clk_i) disable iff (reset_i)
            cnt_q <= CntWidth'(Depth));
    end

endmodule

`default_nettype wire

/* hdl/dma_mem_write.sv */
// Writes one destination word per request with byte enables
// Response error is always zero
`timescale 1ns/1ps
`default_nettype none

module dma_mem_write (
    input  logic                                       clk_i,
    input  logic                                       reset_i,
    input  dma_pkg::w_dp_req_t                         req_i,
    input  logic                                       valid_i,
    output logic                                       ready_o,
    output dma_pkg::w_dp_rsp_t                         rsp_o,
    output logic                                       rsp_valid_o,
    input  logic                                       rsp_ready_i,
    input  dma_pkg::byte_t [dma_pkg::StrbWidth-1:0]    lane_data_i,
    input  dma_pkg::strb_t                             lane_valid_i,
    output dma_pkg::strb_t                             lane_ready_o,
    output dma_pkg::mem_wr_req_t                       mem_req_o,
    input  dma_pkg::mem_wr_rsp_t                       mem_rsp_i
);

    typedef enum logic [1:0] {
        WR_WAIT_DATA,
        WR_WRITE,
        WR_RESPOND
    } wr_state_e;

    wr_state_e      state_q, state_d;
    dma_pkg::strb_t be;

    assign be = dma_pkg::lane_mask(req_i.offset, req_i.num_bytes);

    // ------------------------------------------------------------
    // Next state and outputs
    // ------------------------------------------------------------
    always_comb begin
        state_d         = state_q;
        mem_req_o       = '0;
        mem_req_o.addr  = req_i.addr;
        mem_req_o.be    = be;
        // Disabled lanes drive zero since the buffer keeps filling behind the head
        for (int unsigned i = 0; i < dma_pkg::StrbWidth; i++) begin
            mem_req_o.wdata[8*i +: 8] = be[i] ? lane_data_i[i] : 8'h00;
        end
        lane_ready_o    = '0;
        rsp_valid_o     = 1'b0;
        ready_o         = 1'b0;
        case (state_q)
            WR_WAIT_DATA: begin
                // All requested lanes must be at the buffer head
                if (valid_i && ((lane_valid_i & be) == be)) begin
                    state_d = WR_WRITE;
                end
            end
            WR_WRITE: begin
                mem_req_o.req = 1'b1;
                if (mem_rsp_i.gnt) begin
                    lane_ready_o = be;
                    state_d      = WR_RESPOND;
                end
            end
            WR_RESPOND: begin
                rsp_valid_o = 1'b1;
                if (rsp_ready_i) begin
                    ready_o = 1'b1;
                    state_d = WR_WAIT_DATA;
                end
            end
            default: state_d = WR_WAIT_DATA;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= WR_WAIT_DATA;
        end else begin
            state_q <= state_d;
        end
    end

    assign rsp_o = '0;

    // Address, data and enables hold until the memory grants
    a_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        mem_req_o.req && !mem_rsp_i.gnt |=> $stable(mem_req_o));

endmodule

`default_nettype wire

/* hdl/dma_transport_layer.sv */
// DMA transport layer: MEM or INIT source, per-lane buffer, memory write port
// One read and one write request are handled at a time
`timescale 1ns/1ps
`default_nettype none

module dma_transport_layer (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  dma_pkg::r_dp_req_t     r_dp_req_i,
    input  logic                   r_dp_valid_i,
    output logic                   r_dp_ready_o,
    output logic                   r_dp_valid_o,
    input  logic                   r_dp_ready_i,
    input  dma_pkg::w_dp_req_t     w_dp_req_i,
    input  logic                   w_dp_valid_i,
    output logic                   w_dp_ready_o,
    output dma_pkg::w_dp_rsp_t     w_dp_rsp_o,
    output logic                   w_dp_valid_o,
    input  logic                   w_dp_ready_i,
    output dma_pkg::mem_rd_req_t   mem_rd_req_o,
    input  dma_pkg::mem_rd_rsp_t   mem_rd_rsp_i,
    output dma_pkg::mem_wr_req_t   mem_wr_req_o,
    input  dma_pkg::mem_wr_rsp_t   mem_wr_rsp_i,
    output logic                   r_dp_busy_o,
    output logic                   w_dp_busy_o,
    output logic                   buffer_busy_o
);

    localparam int unsigned Lanes = dma_pkg::StrbWidth;

    logic                       is_init;
    logic                       mem_done, init_done;
    dma_pkg::byte_t [Lanes-1:0] mem_data, init_data, src_data;
    dma_pkg::strb_t             mem_valid, init_valid, src_valid, src_ready;
    dma_pkg::byte_t [2*Lanes-1:0] data_tmp;
    logic [2*Lanes-1:0]         valid_tmp, ready_tmp;
    dma_pkg::byte_t [Lanes-1:0] buf_in_data, buf_out_data;
    dma_pkg::strb_t             buf_in_valid, buf_in_ready;
    dma_pkg::strb_t             buf_out_valid, buf_out_ready;

    assign is_init = (r_dp_req_i.src_protocol == dma_pkg::PROTO_INIT);

    // ------------------------------------------------------------
    // Read sources
    // ------------------------------------------------------------
    dma_mem_read i_mem_read (
        .clk_i        ( clk_i                        ),
        .reset_i      ( reset_i                      ),
        .req_i        ( r_dp_req_i                   ),
        .valid_i      ( r_dp_valid_i && !is_init     ),
        .done_o       ( mem_done                     ),
        .done_ready_i ( r_dp_ready_i && !is_init     ),
        .mem_req_o    ( mem_rd_req_o                 ),
        .mem_rsp_i    ( mem_rd_rsp_i                 ),
        .lane_data_o  ( mem_data                     ),
        .lane_valid_o ( mem_valid                    ),
        .lane_ready_i ( src_ready                    )
    );

    dma_init_read i_init_read (
        .clk_i        ( clk_i                        ),
        .reset_i      ( reset_i                      ),
        .req_i        ( r_dp_req_i                   ),
        .valid_i      ( r_dp_valid_i && is_init      ),
        .done_o       ( init_done                    ),
        .done_ready_i ( r_dp_ready_i && is_init      ),
        .lane_data_o  ( init_data                    ),
        .lane_valid_o ( init_valid                   ),
        .lane_ready_i ( src_ready                    )
    );

    assign src_data     = is_init ? init_data : mem_data;
    assign src_valid    = is_init ? init_valid : mem_valid;
    assign r_dp_valid_o = is_init ? init_done : mem_done;
    assign r_dp_ready_o = r_dp_valid_o && r_dp_ready_i;

    // ------------------------------------------------------------
    // Read barrel shifter
    // ------------------------------------------------------------
    // Source lane s lands on buffer lane (s - shift) mod Lanes
    assign data_tmp     = {src_data, src_data} >> (r_dp_req_i.shift * 8);
    assign buf_in_data  = data_tmp[Lanes-1:0];
    assign valid_tmp    = {src_valid, src_valid} >> r_dp_req_i.shift;
    assign buf_in_valid = valid_tmp[Lanes-1:0];

    // Ready goes back the other way
    assign ready_tmp = {buf_in_ready, buf_in_ready} << r_dp_req_i.shift;
    assign src_ready = ready_tmp[2*Lanes-1 -: Lanes];

    dma_byte_buffer i_buffer (
        .clk_i   ( clk_i         ),
        .reset_i ( reset_i       ),
        .data_i  ( buf_in_data   ),
        .valid_i ( buf_in_valid  ),
        .ready_o ( buf_in_ready  ),
        .data_o  ( buf_out_data  ),
        .valid_o ( buf_out_valid ),
        .ready_i ( buf_out_ready )
    );

    dma_mem_write i_mem_write (
        .clk_i        ( clk_i         ),
        .reset_i      ( reset_i       ),
        .req_i        ( w_dp_req_i    ),
        .valid_i      ( w_dp_valid_i  ),
        .ready_o      ( w_dp_ready_o  ),
        .rsp_o        ( w_dp_rsp_o    ),
        .rsp_valid_o  ( w_dp_valid_o  ),
        .rsp_ready_i  ( w_dp_ready_i  ),
        .lane_data_i  ( buf_out_data  ),
        .lane_valid_i ( buf_out_valid ),
        .lane_ready_o ( buf_out_ready ),
        .mem_req_o    ( mem_wr_req_o  ),
        .mem_rsp_i    ( mem_wr_rsp_i  )
    );

    // Busy flags
    assign r_dp_busy_o   = r_dp_valid_i;
    assign w_dp_busy_o   = w_dp_valid_i;
    assign buffer_busy_o = |buf_out_valid;

endmodule

`default_nettype wire

/* verification/tb_dma_transport_layer.sv */
// Testbench for the DMA transport layer with LCG stimulus and memory models
// Source memory answers 0 to 3 cycles after req; ready and gnt stall only in the random phase
`timescale 1ns/1ps
`default_nettype none

module tb_dma_transport_layer;

    localparam int          ClkPeriod    = 40;
    localparam int          NumTransfers = 206;
    localparam int          TimeoutNs    = (NumTransfers * 40 + 200) * ClkPeriod;
    localparam int unsigned Seed         = 79;
    localparam int          MemBytes     = 1024;

    typedef struct packed {
        dma_pkg::protocol_e proto;
        logic [7:0]         src_addr;
        logic [1:0]         src_off;
        logic [7:0]         dst_addr;
        logic [1:0]         dst_off;
        logic [2:0]         len;
        dma_pkg::byte_t     fill;
    } xfer_t;

    logic                  clk_i = 1'b0;
    logic                  reset_i;
    dma_pkg::r_dp_req_t    r_dp_req_i;
    logic                  r_dp_valid_i;
    logic                  r_dp_ready_o;
    logic                  r_dp_valid_o;
    logic                  r_dp_ready_i;
    dma_pkg::w_dp_req_t    w_dp_req_i;
    logic                  w_dp_valid_i;
    logic                  w_dp_ready_o;
    dma_pkg::w_dp_rsp_t    w_dp_rsp_o;
    logic                  w_dp_valid_o;
    logic                  w_dp_ready_i;
    dma_pkg::mem_rd_req_t  mem_rd_req_o;
    dma_pkg::mem_rd_rsp_t  mem_rd_rsp_i;
    dma_pkg::mem_wr_req_t  mem_wr_req_o;
    dma_pkg::mem_wr_rsp_t  mem_wr_rsp_i;
    logic                  r_dp_busy_o;
    logic                  w_dp_busy_o;
    logic                  buffer_busy_o;

    xfer_t                 xfers [NumTransfers];
    dma_pkg::byte_t        dst_mem [MemBytes];
    dma_pkg::byte_t        exp_mem [MemBytes];
    int                    reads_done;
    int                    wr_checked;
    int                    checks;
    int                    errors;
    logic                  stall_en;
    logic                  idle_check;
    logic                  final_check;
    logic                  final_done;

    dma_transport_layer UUT (.*);

    always #(ClkPeriod / 2) clk_i = ~clk_i;

    // ------------------------------------------------------------
    // Helpers and reference model
    // ------------------------------------------------------------
    function automatic int unsigned lcg_next(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int pick(input int unsigned state, input int range);
        return int'((state >> 16) % range);
    endfunction

    // Source memory content
    function automatic dma_pkg::byte_t src_byte(input int byte_addr);
        return 8'(3 * byte_addr + 1);
    endfunction

    // Initial destination content, upper address bits folded in
    function automatic dma_pkg::byte_t dst_fill(input int byte_addr);
        return 8'(byte_addr * 13 + (byte_addr >> 8) + 'h5A);
    endfunction

    // Byte k of a transfer, lands on destination lane dst_off + k
    function automatic dma_pkg::byte_t expected_byte(input xfer_t x, input int k);
        if (x.proto == dma_pkg::PROTO_INIT) begin
            return x.fill;
        end
        return src_byte(int'(x.src_addr) * 4 + int'(x.src_off) + k);
    endfunction

    function automatic string test_name(input int idx);
        case (idx)
            0: return "aligned_mem";
            1: return "misaligned_mem";
            2: return "init_fill";
            3, 4, 5: return "depth_in_flight";
            default: return "random_mix";
        endcase
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    // ------------------------------------------------------------
    // Request drivers, called and returning at 2 ns after an edge
    // ------------------------------------------------------------
    task automatic read_transfer(input xfer_t x);
        r_dp_req_i.src_protocol = x.proto;
        r_dp_req_i.addr         = x.src_addr;
        r_dp_req_i.offset       = x.src_off;
        r_dp_req_i.num_bytes    = x.len;
        r_dp_req_i.shift        = x.src_off - x.dst_off;
        r_dp_req_i.fill_byte    = x.fill;
        r_dp_valid_i            = 1'b1;
        @(negedge clk_i);
        while (!r_dp_ready_o) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #2;
        r_dp_valid_i = 1'b0;
        reads_done++;
    endtask

    task automatic write_transfer(input xfer_t x);
        w_dp_req_i.addr      = x.dst_addr;
        w_dp_req_i.offset    = x.dst_off;
        w_dp_req_i.num_bytes = x.len;
        w_dp_valid_i         = 1'b1;
        @(negedge clk_i);
        while (!w_dp_ready_o) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #2;
        w_dp_valid_i = 1'b0;
    endtask

    task automatic run_transfers(input int first, input int last, input logic reads_first);
        int ri;
        int wi;
        fork
            begin
                for (ri = first; ri < last; ri++) begin
                    read_transfer(xfers[ri]);
                end
            end
            begin
                if (reads_first) begin
                    wait (reads_done == last);
                    @(posedge clk_i);
                    #2;
                end
                for (wi = first; wi < last; wi++) begin
                    write_transfer(xfers[wi]);
                end
            end
        join
    endtask

    // ------------------------------------------------------------
    // Memory models and stall generator
    // ------------------------------------------------------------
    initial begin : memory_models
        int unsigned rnd;
        int          rd_wait;
        logic        rd_pending;
        int          rd_base;
        int          a;
        int          k;
        rnd          = lcg_next(Seed);
        rd_wait      = 0;
        rd_pending   = 1'b0;
        rd_base      = 0;
        mem_rd_rsp_i = '0;
        mem_wr_rsp_i = '0;
        r_dp_ready_i = 1'b0;
        w_dp_ready_i = 1'b0;
        for (a = 0; a < MemBytes; a++) begin
            dst_mem[a] = dst_fill(a);
        end
        forever begin
            @(negedge clk_i);
            if (!reset_i && mem_wr_req_o.req && mem_wr_rsp_i.gnt) begin
                for (k = 0; k < 4; k++) begin
                    if (mem_wr_req_o.be[k]) begin
                        dst_mem[int'(mem_wr_req_o.addr) * 4 + k] = mem_wr_req_o.wdata[8*k +: 8];
                    end
                end
            end
            if (!reset_i && mem_rd_req_o.req) begin
                rnd        = lcg_next(rnd);
                rd_wait    = pick(rnd, 4);
                rd_base    = int'(mem_rd_req_o.addr) * 4;
                rd_pending = 1'b1;
            end
            @(posedge clk_i);
            #2;
            mem_rd_rsp_i = '0;
            if (rd_pending && rd_wait == 0) begin
                mem_rd_rsp_i.rvalid = 1'b1;
                for (k = 0; k < 4; k++) begin
                    mem_rd_rsp_i.rdata[8*k +: 8] = src_byte(rd_base + k);
                end
                rd_pending = 1'b0;
            end else if (rd_pending) begin
                rd_wait--;
            end
            // About one stall cycle in four per signal
            rnd              = lcg_next(rnd);
            r_dp_ready_i     = !stall_en || (rnd[17:16] != 2'b00);
            w_dp_ready_i     = !stall_en || (rnd[19:18] != 2'b00);
            mem_wr_rsp_i.gnt = !stall_en || (rnd[21:20] != 2'b00);
        end
    end

    // ------------------------------------------------------------
    // Compare process
    // ------------------------------------------------------------
    initial begin : compare
        int    a;
        int    k;
        int    base;
        xfer_t x;
        logic  r_valid_held;
        logic  w_valid_held;
        checks       = 0;
        errors       = 0;
        wr_checked   = 0;
        final_done   = 1'b0;
        r_valid_held = 1'b0;
        w_valid_held = 1'b0;
        for (a = 0; a < MemBytes; a++) begin
            exp_mem[a] = dst_fill(a);
        end
        forever begin
            @(negedge clk_i);
            if (idle_check) begin
                check_value("idle_r_busy", 0, int'(r_dp_busy_o));
                check_value("idle_w_busy", 0, int'(w_dp_busy_o));
                check_value("idle_buffer_busy", 0, int'(buffer_busy_o));
                check_value("idle_mem_rd_req", 0, int'(mem_rd_req_o.req));
                check_value("idle_mem_wr_req", 0, int'(mem_wr_req_o.req));
                check_value("idle_r_valid", 0, int'(r_dp_valid_o));
                check_value("idle_w_valid", 0, int'(w_dp_valid_o));
            end
            // Completion and response valid hold until accepted
            if (!reset_i && r_valid_held) begin
                check_value("r_valid_hold", 1, int'(r_dp_valid_o));
            end
            if (!reset_i && w_valid_held) begin
                check_value("w_valid_hold", 1, int'(w_dp_valid_o));
            end
            r_valid_held = !reset_i && r_dp_valid_o && !r_dp_ready_i;
            w_valid_held = !reset_i && w_dp_valid_o && !w_dp_ready_i;
            if (!reset_i && w_dp_valid_o && w_dp_ready_i) begin
                assert (wr_checked < NumTransfers) else begin
                    errors++;
                    $display("write response arrived with no transfer left to match");
                end
                if (wr_checked < NumTransfers) begin
                    x    = xfers[wr_checked];
                    base = int'(x.dst_addr) * 4;
                    for (k = 0; k < int'(x.len); k++) begin
                        exp_mem[base + int'(x.dst_off) + k] = expected_byte(x, k);
                    end
                    // Whole word, so untouched lanes are covered too
                    for (k = 0; k < 4; k++) begin
                        check_value(test_name(wr_checked), int'(exp_mem[base + k]),
                                    int'(dst_mem[base + k]));
                    end
                    check_value("rsp_error", 0, int'(w_dp_rsp_o.error));
                end
                wr_checked++;
            end
            if (final_check && !final_done) begin
                for (a = 0; a < MemBytes; a++) begin
                    check_value("final_memory", int'(exp_mem[a]), int'(dst_mem[a]));
                end
                assert (wr_checked == NumTransfers) else begin
                    errors++;
                    $display("only %0d of %0d write responses were seen", wr_checked, NumTransfers);
                end
                final_done = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin : stimulus
        int          i;
        int          len;
        int unsigned rnd;
        reset_i      = 1'b1;
        r_dp_req_i   = '0;
        r_dp_valid_i = 1'b0;
        w_dp_req_i   = '0;
        w_dp_valid_i = 1'b0;
        stall_en     = 1'b0;
        idle_check   = 1'b0;
        final_check  = 1'b0;
        reads_done   = 0;
        // Aligned copy, misaligned copy with shift 3, fill with shift 1
        xfers[0] = '{dma_pkg::PROTO_MEM, 8'd10, 2'd0, 8'd20, 2'd0, 3'd4, 8'h00};
        xfers[1] = '{dma_pkg::PROTO_MEM, 8'd11, 2'd1, 8'd21, 2'd2, 3'd2, 8'h00};
        xfers[2] = '{dma_pkg::PROTO_INIT, 8'd0, 2'd2, 8'd22, 2'd1, 3'd2, 8'hC3};
        for (i = 3; i < 6; i++) begin
            xfers[i] = '{dma_pkg::PROTO_MEM, 8'(27 + i), 2'd0, 8'(37 + i), 2'd0, 3'd4, 8'h00};
        end
        rnd = Seed;
        for (i = 6; i < NumTransfers; i++) begin
            rnd               = lcg_next(rnd);
            len               = 1 + pick(rnd, 4);
            xfers[i].len      = 3'(len);
            rnd               = lcg_next(rnd);
            xfers[i].src_off  = 2'(pick(rnd, 5 - len));
            rnd               = lcg_next(rnd);
            xfers[i].dst_off  = 2'(pick(rnd, 5 - len));
            rnd               = lcg_next(rnd);
            xfers[i].src_addr = 8'(pick(rnd, 256));
            rnd               = lcg_next(rnd);
            xfers[i].dst_addr = 8'(64 + pick(rnd, 192));
            rnd               = lcg_next(rnd);
            xfers[i].fill     = 8'(pick(rnd, 256));
            xfers[i].proto    = (pick(rnd, 4096) < 1024) ? dma_pkg::PROTO_INIT
                                                         : dma_pkg::PROTO_MEM;
        end
        repeat (5) @(posedge clk_i);
        #2;
        reset_i    = 1'b0;
        idle_check = 1'b1;
        repeat (3) @(posedge clk_i);
        #2;
        idle_check = 1'b0;
        run_transfers(0, 3, 1'b0);
        // Three words held in the buffer before the first write
        run_transfers(3, 6, 1'b1);
        stall_en = 1'b1;
        run_transfers(6, NumTransfers, 1'b0);
        repeat (2) @(posedge clk_i);
        #2;
        final_check = 1'b1;
        wait (final_done);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // 40 cycles per transfer plus setup
    initial begin : watchdog
        #(TimeoutNs);
        $display("run timed out after %0d ns with %0d of %0d transfers written",
                 TimeoutNs, wr_checked, NumTransfers);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
hdl/dma_pkg.sv
hdl/dma_mem_read.sv
hdl/dma_init_read.sv
hdl/dma_byte_buffer.sv
hdl/dma_mem_write.sv
hdl/dma_transport_layer.sv
verification/tb_dma_transport_layer.sv

/* run.sh */
#!/bin/sh
# Builds and runs the testbench with Verilator, pass is decided from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f \
    --top-module tb_dma_transport_layer -o sim_dma
./obj_dir/sim_dma | tee sim.log

if grep -q "^sim passed$" sim.log; then
    exit 0
fi
exit 1
